/* build.f */
common/fact_pkg.sv
hw/fact_regs.sv
fact_engine/fact_multiplier.sv
fact_engine/fact_engine.sv
hw/fact_top.sv
tests/fact_properties.sv
tests/fact_tb.sv

/* Makefile */
# Verilator flow for the factorial accelerator

VERILATOR ?= verilator
TOP       ?= fact_tb
RTL_TOP   ?= fact_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --timing --assert
BUILD_OPT ?= --binary -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(BUILD_OPT) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/fact_tb.sv */
`timescale 1ns/1ps

module fact_tb;
	import fact_pkg::*;

	localparam int FLAG_POLL_LIMIT = 5000;          // flag reads before a wait gives up
	localparam int RANDOM_RUNS     = 6;             // random N runs, last one past 34

	logic  clk = 1'b0;
	logic  reset_n;
	logic  sel;
	logic  wr;
	addr_t address;
	word_t din;
	word_t dout;
	logic  interrupt;

	event  cmp_ev;                                  // wakes the compare process
	string cmp_name;
	word_t cmp_expected;
	word_t cmp_actual;
	int    error_count = 0;

	fact_top u_fact_top (
		.clk       (clk),
		.reset_n   (reset_n),
		.sel       (sel),
		.wr        (wr),
		.address   (address),
		.din       (din),
		.dout      (dout),
		.interrupt (interrupt)
	);

	always #20 clk = ~clk;                          // 40 ns period

	// N! mod 2^128 by repeated multiplication
	function automatic product_t factorial_ref(input int unsigned value);
		product_t prod;
		prod = product_t'(1);
		for (int unsigned i = 2; i <= value; i++)
			prod = prod * product_t'(i);            // high bits drop off like the hardware
		return prod;
	endfunction

	// compare process, one check per posted sample
	initial begin
		forever begin
			@(cmp_ev);
			assert (cmp_actual === cmp_expected) else begin
				error_count++;
				$display("[ERROR] %s: expected %h, actual %h", cmp_name, cmp_expected,
				         cmp_actual);
				$display("Test failed");
				$fatal(1, "run stopped at first mismatch");
			end
		end
	end

	task automatic post_compare(input string name, input word_t expected, input word_t actual);
		cmp_name     = name;
		cmp_expected = expected;
		cmp_actual   = actual;
		-> cmp_ev;
	endtask

	task automatic write_reg(input addr_t addr, input word_t data);
		@(posedge clk);
		sel     <= 1'b1;
		wr      <= 1'b1;
		address <= addr;
		din     <= data;
		@(posedge clk);                             // register takes the write here
		sel <= 1'b0;
		wr  <= 1'b0;
	endtask

	task automatic read_reg(input addr_t addr, output word_t data);
		@(posedge clk);
		sel     <= 1'b1;
		wr      <= 1'b0;
		address <= addr;
		din     <= '0;
		@(negedge clk);
		data = dout;                                // comb read, settled mid cycle
		@(posedge clk);
		sel <= 1'b0;
	endtask

	task automatic expect_reg(input string name, input addr_t addr, input word_t expected);
		word_t value;
		read_reg(addr, value);
		post_compare(name, expected, value);
	endtask

	task automatic sample_interrupt(input string name, input logic expected);
		@(negedge clk);
		post_compare(name, word_t'(expected), word_t'(interrupt));
	endtask

	// poll the flag until set, bounded
	task automatic wait_for_flag(input string name);
		word_t flag;
		int    polls;
		flag  = '0;
		polls = 0;
		while ((flag[0] !== 1'b1) && (polls < FLAG_POLL_LIMIT)) begin
			read_reg(ADDR_INT_FLAG, flag);
			polls++;
		end
		if (flag[0] !== 1'b1) begin
			$display("%s: completion flag never set after %0d polls", name, FLAG_POLL_LIMIT);
			$display("Test failed");
			$fatal(1, "timeout waiting for completion");
		end
	endtask

	task automatic launch(input word_t value);
		write_reg(ADDR_INT_FLAG, '0);               // clear old completion
		write_reg(ADDR_N, value);
		write_reg(ADDR_START, word_t'(1));
	endtask

	task automatic verify_result(input string name, input word_t value);
		product_t expected;
		expected = factorial_ref(value);
		for (int i = 0; i < RESULT_WORDS; i++)
			expect_reg($sformatf("%s word %0d", name, i), ADDR_RESULT0 + addr_t'(i),
			           expected[i*WORD_W +: WORD_W]);   // lsw first
	endtask

	initial begin
		word_t value;
		word_t n_first;
		word_t n_second;
		void'($urandom(32'hcbe4_4ec6));
		sel     = 1'b0;
		wr      = 1'b0;
		address = '0;
		din     = '0;
		reset_n = 1'b0;
		repeat (3) @(posedge clk);
		reset_n <= 1'b1;

		// register access after reset
		expect_reg("reset n", ADDR_N, '0);
		expect_reg("reset int_enable", ADDR_INT_ENABLE, '0);
		expect_reg("reset flag", ADDR_INT_FLAG, '0);
		for (int i = 0; i < RESULT_WORDS; i++)
			expect_reg($sformatf("reset result %0d", i), ADDR_RESULT0 + addr_t'(i), '0);
		value = $urandom;
		write_reg(ADDR_N, value);
		expect_reg("n readback", ADDR_N, value);
		value = $urandom;
		write_reg(ADDR_INT_ENABLE, value);
		expect_reg("int_enable readback", ADDR_INT_ENABLE, value);
		write_reg(ADDR_INT_ENABLE, '0);
		expect_reg("start reg reads 0", ADDR_START, '0);
		expect_reg("unmapped 0x08", 8'h08, '0);

		// small N, short path and single multiply
		for (int k = 0; k <= 2; k++) begin
			launch(word_t'(k));
			wait_for_flag($sformatf("small n=%0d", k));
			verify_result($sformatf("small n=%0d", k), word_t'(k));
		end

		// random N in 3..40
		for (int k = 0; k < RANDOM_RUNS; k++) begin
			if (k == RANDOM_RUNS - 1)
				value = word_t'(35 + $urandom % 6);  // past 34 the product wraps
			else
				value = word_t'(3 + $urandom % 38);
			launch(value);
			wait_for_flag($sformatf("random n=%0d", value));
			verify_result($sformatf("random n=%0d", value), value);
		end

		// interrupt gating and clear
		launch(word_t'(5));
		wait_for_flag("irq disabled");
		sample_interrupt("irq low while disabled", 1'b0);
		write_reg(ADDR_INT_ENABLE, word_t'(1));
		sample_interrupt("irq high once enabled", 1'b1);
		write_reg(ADDR_INT_FLAG, word_t'(7));      // nonzero write leaves the flag
		expect_reg("flag kept on nonzero write", ADDR_INT_FLAG, word_t'(1));
		write_reg(ADDR_INT_FLAG, '0);
		expect_reg("flag cleared", ADDR_INT_FLAG, '0);
		sample_interrupt("irq cleared with flag", 1'b0);
		launch(word_t'(4));
		wait_for_flag("irq enabled");
		sample_interrupt("irq high on completion", 1'b1);
		write_reg(ADDR_INT_FLAG, '0);
		sample_interrupt("irq low after clear", 1'b0);
		write_reg(ADDR_INT_ENABLE, '0);

		// second start while the engine is busy
		n_first  = word_t'(20 + $urandom % 10);
		n_second = n_first + word_t'(7);
		launch(n_first);
		write_reg(ADDR_N, n_second);
		expect_reg("flag low while busy", ADDR_INT_FLAG, '0);
		write_reg(ADDR_START, word_t'(1));         // engine not idle, ignored
		wait_for_flag("busy first");
		verify_result("start while busy", n_first);
		write_reg(ADDR_INT_FLAG, '0);
		write_reg(ADDR_START, word_t'(1));         // N register still holds n_second
		wait_for_flag("busy second");
		verify_result("later start", n_second);

		@(posedge clk);                             // compare process takes the last sample

		if (error_count == 0) begin
			$display("Test passed");
			$finish;
		end else begin
			$display("Test failed");
			$fatal(1, "%0d checks failed", error_count);
		end
	end

endmodule

/* tests/fact_properties.sv */
`timescale 1ns/1ps

module fact_properties (
	input logic clk,
	input logic reset_n,
	input logic interrupt,
	input logic enable_bit,                     // int_enable bit 0
	input logic done,
	input logic mul_start,
	input logic mul_done,
	input logic mul_busy
);

	logic mul_pending;                          // multiply running or just finishing

	assign mul_pending = mul_busy || mul_done;

	// done sets the flag, so interrupt then follows the enable bit
	interrupt_after_done: assert property (
		@(posedge clk) disable iff (!reset_n) done |=> (interrupt == enable_bit)
	) else $error("interrupt does not match enable bit after completion");

	done_single_cycle: assert property (
		@(posedge clk) disable iff (!reset_n) done |=> !done
	) else $error("done held longer than one cycle");

	mul_start_single_cycle: assert property (
		@(posedge clk) disable iff (!reset_n) mul_start |=> !mul_start
	) else $error("mul_start held longer than one cycle");

	// engine waits for mul_done before the next round
	no_start_while_pending: assert property (
		@(posedge clk) disable iff (!reset_n) mul_start |-> !mul_pending
	) else $error("mul_start pulsed during a multiplication");

endmodule

bind fact_top fact_properties u_fact_properties (
	.clk        (clk),
	.reset_n    (reset_n),
	.interrupt  (interrupt),
	.enable_bit (u_fact_regs.int_enable_q[0]),
	.done       (done),
	.mul_start  (u_fact_engine.mul_start),
	.mul_done   (u_fact_engine.mul_done),
	.mul_busy   (u_fact_engine.u_fact_multiplier.busy)
);

/* hw/fact_top.sv */
`timescale 1ns/1ps

module fact_top (
	input  logic            clk,
	input  logic            reset_n,
	input  logic            sel,
	input  logic            wr,
	input  fact_pkg::addr_t address,
	input  fact_pkg::word_t din,
	output fact_pkg::word_t dout,
	output logic            interrupt
);
	import fact_pkg::*;

	logic     start;                                // regs to engine, one cycle
	word_t    n;                                    // current N register
	logic     done;                                 // engine to regs, one cycle
	product_t result;                               // valid with done

	// host register block
	fact_regs u_fact_regs (
		.clk       (clk),
		.reset_n   (reset_n),
		.sel       (sel),
		.wr        (wr),
		.address   (address),
		.din       (din),
		.done      (done),
		.result    (result),
		.dout      (dout),
		.interrupt (interrupt),
		.start     (start),
		.n         (n)
	);

	// factorial sequencer with its multiplier
	fact_engine u_fact_engine (
		.clk     (clk),
		.reset_n (reset_n),
		.start   (start),
		.n       (n),
		.done    (done),
		.result  (result)
	);

endmodule

/* fact_engine/fact_engine.sv */
`timescale 1ns/1ps

module fact_engine (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               start,
	input  fact_pkg::word_t    n,
	output logic               done,
	output fact_pkg::product_t result
);
	import fact_pkg::*;

	engine_state_t state;

	product_t product_q;                            // running product
	word_t    factor_q;                             // descending factor

	logic     accept;                               // start taken this cycle
	logic     small_n;                              // n of 0 or 1
	logic     last_round;                           // current multiply is the final one
	logic     mul_start;
	logic     mul_done;
	product_t mul_product;

	assign accept     = (state == ENG_IDLE) && start;   // start ignored unless idle
	assign small_n    = (n <= word_t'(1));
	assign last_round = (factor_q <= word_t'(2));       // factor 1 only seen for n of 2
	assign mul_start  = (state == ENG_MUL_START);

	fact_multiplier u_fact_multiplier (
		.clk          (clk),
		.reset_n      (reset_n),
		.mul_start    (mul_start),
		.multiplicand (product_q),              // held until mul_done
		.factor       (factor_q),
		.mul_done     (mul_done),
		.mul_product  (mul_product)
	);

	// sequencer
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= ENG_IDLE;
		end else begin
			case (state)
				ENG_IDLE: begin
					if (accept)
						state <= small_n ? ENG_DONE : ENG_MUL_START;
				end
				ENG_MUL_START: begin
					state <= ENG_MUL_WAIT;          // mul_start pulses here
				end
				ENG_MUL_WAIT: begin
					if (mul_done)
						state <= last_round ? ENG_DONE : ENG_MUL_START;
				end
				ENG_DONE: begin
					state <= ENG_IDLE;
				end
				default: begin
					state <= ENG_IDLE;
				end
			endcase
		end
	end

	// done is registered, one cycle after ENG_DONE
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			done <= 1'b0;
		else
			done <= (state == ENG_DONE);
	end

	// product and factor
	always_ff @(posedge clk) begin
		if (accept) begin
			if (small_n) begin
				product_q <= product_t'(1);         // 0! = 1! = 1
			end else begin
				product_q <= product_t'(n);         // seed with n
				factor_q  <= n - word_t'(1);
			end
		end else if ((state == ENG_MUL_WAIT) && mul_done) begin
			product_q <= mul_product;
			factor_q  <= factor_q - word_t'(1);
		end
	end

	assign result = product_q;                      // stable through the done cycle

endmodule

/* fact_engine/fact_multiplier.sv */
`timescale 1ns/1ps

module fact_multiplier (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               mul_start,
	input  fact_pkg::product_t multiplicand,
	input  fact_pkg::word_t    factor,
	output logic               mul_done,
	output fact_pkg::product_t mul_product
);
	import fact_pkg::*;

	logic              busy;                        // multiply in progress
	logic [STEP_W-1:0] step_q;                      // factor bit being tested
	logic              last_step;

	product_t mcand_q;                              // shifted multiplicand
	word_t    mplier_q;                             // remaining factor bits, lsb next
	product_t acc_q;                                // partial product

	assign last_step = busy && (step_q == STEP_W'(MUL_STEPS - 1));

	// step control
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy     <= 1'b0;
			step_q   <= '0;
			mul_done <= 1'b0;
		end else begin
			mul_done <= last_step;                  // single pulse after the last step
			if (mul_start) begin
				busy   <= 1'b1;
				step_q <= '0;
			end else if (busy) begin
				step_q <= step_q + STEP_W'(1);
				if (last_step)
					busy <= 1'b0;
			end
		end
	end

	// shift-add datapath
	always_ff @(posedge clk) begin
		if (mul_start) begin
			acc_q    <= '0;
			mcand_q  <= multiplicand;
			mplier_q <= factor;
		end else if (busy) begin
			if (mplier_q[0])
				acc_q <= acc_q + mcand_q;           // wraps mod 2^128
			mcand_q  <= mcand_q << 1;               // upper bits fall off
			mplier_q <= mplier_q >> 1;
		end
	end

	assign mul_product = acc_q;

endmodule

/* hw/fact_regs.sv */
`timescale 1ns/1ps

module fact_regs (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               sel,
	input  logic               wr,
	input  fact_pkg::addr_t    address,
	input  fact_pkg::word_t    din,
	input  logic               done,
	input  fact_pkg::product_t result,
	output fact_pkg::word_t    dout,
	output logic               interrupt,
	output logic               start,
	output fact_pkg::word_t    n
);
	import fact_pkg::*;

	word_t n_q;                                     // N register
	word_t int_enable_q;                            // enable register, full word kept
	logic  flag_q;                                  // completion flag
	word_t result_q [RESULT_WORDS];                 // product words, lsw at index 0

	logic  wr_en;                                   // host write strobe
	logic  rd_en;                                   // host read strobe
	logic  is_result;                               // address hits a result word
	addr_t result_offset;
	logic [RESULT_IDX_W-1:0] result_idx;

	assign wr_en = sel && wr;
	assign rd_en = sel && !wr;

	assign is_result     = (address >= ADDR_RESULT0) &&
	                       (address < ADDR_RESULT0 + addr_t'(RESULT_WORDS));
	assign result_offset = address - ADDR_RESULT0;
	assign result_idx    = result_offset[RESULT_IDX_W-1:0];   // low bits select the word

	// host writable registers
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			n_q          <= '0;
			int_enable_q <= '0;
		end else if (wr_en) begin
			if (address == ADDR_N)
				n_q <= din;                         // N read back as written
			if (address == ADDR_INT_ENABLE)
				int_enable_q <= din;
		end
	end

	// start command, one cycle after the write edge
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			start <= 1'b0;
		else
			start <= wr_en && (address == ADDR_START) && din[0];
	end

	// completion flag
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			flag_q <= 1'b0;
		else if (done)
			flag_q <= 1'b1;                         // done wins over a clear in the same cycle
		else if (wr_en && (address == ADDR_INT_FLAG) && (din == '0))
			flag_q <= 1'b0;                         // only an all-zero write clears
	end

	// capture product on done
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < RESULT_WORDS; i++)
				result_q[i] <= '0;
		end else if (done) begin
			for (int i = 0; i < RESULT_WORDS; i++)
				result_q[i] <= result[i*WORD_W +: WORD_W];  // slice word i
		end
	end

	// combinational read mux
	always_comb begin
		dout = '0;                                  // idle or unmapped reads give 0
		if (rd_en) begin
			if (is_result) begin
				dout = result_q[result_idx];
			end else begin
				case (address)
					ADDR_N:          dout = n_q;
					ADDR_INT_ENABLE: dout = int_enable_q;
					ADDR_INT_FLAG:   dout = word_t'(flag_q);
					default:         dout = '0;     // start reg is write only
				endcase
			end
		end
	end

	assign interrupt = flag_q && int_enable_q[0];   // enable gates the flag
	assign n         = n_q;

endmodule

/* common/fact_pkg.sv */
package fact_pkg;

	// basic widths
	localparam int ADDR_W       = 8;                        // slave address width
	localparam int WORD_W       = 32;                       // bus word and factor width
	localparam int RESULT_WORDS = 4;                        // words per product
	localparam int PRODUCT_W    = WORD_W * RESULT_WORDS;    // 128 bit product

	// multiplier iteration count
	localparam int MUL_STEPS = WORD_W;                      // one factor bit per step
	localparam int STEP_W    = $clog2(MUL_STEPS);           // step counter width

	// index into the result words
	localparam int RESULT_IDX_W = $clog2(RESULT_WORDS);

	typedef logic [ADDR_W-1:0]    addr_t;                   // slave register address
	typedef logic [WORD_W-1:0]    word_t;                   // data word, factor value
	typedef logic [PRODUCT_W-1:0] product_t;                // factorial product mod 2^128

	// register map
	localparam addr_t ADDR_N          = 8'h00;              // N, read/write
	localparam addr_t ADDR_INT_ENABLE = 8'h01;              // interrupt enable, bit 0 used
	localparam addr_t ADDR_INT_FLAG   = 8'h02;              // completion flag, write 0 clears
	localparam addr_t ADDR_START      = 8'h03;              // start command, write only
	localparam addr_t ADDR_RESULT0    = 8'h04;              // result word 0, lsw first

	// engine sequencer states
	typedef enum logic [1:0] {
		ENG_IDLE,                                           // waiting for start
		ENG_MUL_START,                                      // pulse mul_start
		ENG_MUL_WAIT,                                       // wait for mul_done
		ENG_DONE                                            // product final
	} engine_state_t;

endpackage
